// File: verilog/marx_topo_pkg.sv
// marx topology package with the core and APU counts and the index widths derived from them
package marx_topo_pkg;

    ////////////////////////////////////////
    // interconnect size
    ////////////////////////////////////////

    // number of cores sharing the APUs
    localparam int n_cpus = 4;

    // number of identical APUs behind the interconnect
    localparam int n_apus = 2;

    ////////////////////////////////////////
    // index widths
    ////////////////////////////////////////

    // width of a core index, which is also the upper field of the extended tag
    localparam int w_cpu_idx = $clog2(n_cpus);

    // width of an APU index that the return path uses to pick a winning APU
    localparam int w_apu_idx = $clog2(n_apus);

endpackage

// File: verilog/apu_op_pkg.sv
// APU operation format package with operand, opcode, type and tag widths and the served type
package apu_op_pkg;

    import marx_topo_pkg::*;

    ////////////////////////////////////////
    // payload widths
    ////////////////////////////////////////

    // operands and results share one width
    localparam int w_operand = 32;
    localparam int n_args    = 2;
    localparam int w_op      = 6;

    ////////////////////////////////////////
    // instruction type and tags
    ////////////////////////////////////////

    localparam int w_type = 2;

    // only requests of this type are routed to the APUs
    localparam logic [w_type-1:0] apu_type = 2'd1;

    // tag that the core attaches to its own request
    localparam int w_cpu_tag = 4;

    // the APU sees the core index above the core tag
    localparam int w_apu_tag = w_cpu_tag + w_cpu_idx;

endpackage

// File: verilog/marx_arbiter.sv
// round-robin arbiter that assigns requesting cores to available APUs each cycle
module marx_arbiter
    import marx_topo_pkg::*;
(
    input  logic                                 clk_ci,
    input  logic                                 rst_n,
    input  logic [n_cpus-1:0]                    req,
    input  logic [n_apus-1:0]                    avail,
    output logic [n_cpus-1:0]                    ack,
    output logic [n_apus-1:0]                    alloc,
    output logic [n_apus-1:0][w_cpu_idx-1:0]     assid
);

    // the core with the highest priority in the current cycle
    logic [w_cpu_idx-1:0] ptr;
    logic [w_cpu_idx-1:0] last_grant;
    logic [w_cpu_idx-1:0] next_ptr;
    logic [n_cpus-1:0]    granted;

    ////////////////////////////////////////
    // grant assignment
    ////////////////////////////////////////

    // each available APU, lowest index first, takes the next requesting core
    // in round-robin order that no earlier APU has taken in this cycle
    always_comb begin
        int  idx;
        logic found;
        granted    = '0;
        alloc      = '0;
        assid      = '0;
        last_grant = ptr;
        for (int a = 0; a < n_apus; a++) begin
            found = 1'b0;
            for (int k = 0; k < n_cpus; k++) begin
                idx = (int'(ptr) + k) % n_cpus;
                if (!found && avail[a] && req[idx] && !granted[idx]) begin
                    found        = 1'b1;
                    granted[idx] = 1'b1;
                    alloc[a]     = 1'b1;
                    assid[a]     = w_cpu_idx'(idx);
                    // later APUs only ever pick cores further along the scan
                    last_grant   = w_cpu_idx'(idx);
                end
            end
        end
    end

    // a core is acknowledged in the same cycle that it is granted
    assign ack = granted;

    ////////////////////////////////////////
    // round-robin pointer
    ////////////////////////////////////////

    // priority moves to the core after the last one served
    assign next_ptr = (int'(last_grant) == n_cpus - 1) ? '0 : last_grant + 1'b1;

    // the pointer only moves after a cycle that granted something
    always_ff @(posedge clk_ci) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|alloc) begin
            ptr <= next_ptr;
        end
    end

endmodule

// File: verilog/marx_dispatch.sv
// dispatch path that filters requests by type, arbitrates and routes core payloads to the APUs
module marx_dispatch
    import marx_topo_pkg::*;
    import apu_op_pkg::*;
(
    input  logic                                        clk_ci,
    input  logic                                        rst_n,
    // core side
    input  logic [n_cpus-1:0]                           req_ds,
    input  logic [n_cpus-1:0][w_type-1:0]               type_ds,
    input  logic [n_cpus-1:0][w_op-1:0]                 op_ds,
    input  logic [n_cpus-1:0][n_args-1:0][w_operand-1:0] operands_ds,
    input  logic [n_cpus-1:0][w_cpu_tag-1:0]            tag_ds,
    output logic [n_cpus-1:0]                           ack_ds,
    // APU side
    input  logic [n_apus-1:0]                           apu_ready_ds,
    output logic [n_apus-1:0]                           apu_valid_ds,
    output logic [n_apus-1:0][w_op-1:0]                 apu_op_ds,
    output logic [n_apus-1:0][n_args-1:0][w_operand-1:0] apu_operands_ds,
    output logic [n_apus-1:0][w_apu_tag-1:0]            apu_tag_ds
);

    logic [n_cpus-1:0]                type_match;
    logic [n_cpus-1:0]                arb_req;
    logic [n_apus-1:0]                alloc;
    logic [n_apus-1:0][w_cpu_idx-1:0] assid;

    // a request of any other type is invisible to the arbiter
    always_comb begin
        for (int c = 0; c < n_cpus; c++) begin
            type_match[c] = (type_ds[c] == apu_type);
        end
    end

    assign arb_req = req_ds & type_match;

    marx_arbiter i_marx_arbiter (
        .clk_ci (clk_ci),
        .rst_n  (rst_n),
        .req    (arb_req),
        .avail  (apu_ready_ds),
        .ack    (ack_ds),
        .alloc  (alloc),
        .assid  (assid)
    );

    // the arbiter only allocates ready APUs, so this never exceeds ready_ds
    assign apu_valid_ds = alloc;

    ////////////////////////////////////////
    // downstream payload mux
    ////////////////////////////////////////

    // the extended tag carries the core index so the result finds its way back
    always_comb begin
        for (int a = 0; a < n_apus; a++) begin
            if (alloc[a]) begin
                apu_op_ds[a]       = op_ds[assid[a]];
                apu_operands_ds[a] = operands_ds[assid[a]];
                apu_tag_ds[a]      = {assid[a], tag_ds[assid[a]]};
            end else begin
                apu_op_ds[a]       = '0;
                apu_operands_ds[a] = '0;
                apu_tag_ds[a]      = '0;
            end
        end
    end

endmodule

// File: verilog/marx_return.sv
// return path that decodes result tags and routes each core the result of its lowest target APU
module marx_return
    import marx_topo_pkg::*;
    import apu_op_pkg::*;
(
    // APU side
    input  logic [n_apus-1:0]                  apu_req_us,
    input  logic [n_apus-1:0][w_operand-1:0]   apu_result_us,
    input  logic [n_apus-1:0][w_apu_tag-1:0]   apu_tag_us,
    output logic [n_apus-1:0]                  apu_ack_us,
    // core side
    input  logic [n_cpus-1:0]                  ready_us,
    output logic [n_cpus-1:0]                  valid_us,
    output logic [n_cpus-1:0][w_operand-1:0]   result_us,
    output logic [n_cpus-1:0][w_cpu_tag-1:0]   tag_us
);

    // target[a][c] is high when APU a presents a result for core c
    logic [n_apus-1:0][n_cpus-1:0]    target;
    logic [n_cpus-1:0]                hit;
    logic [n_cpus-1:0][w_apu_idx-1:0] win;

    ////////////////////////////////////////
    // target map and priority
    ////////////////////////////////////////

    // the upper tag field is the core that issued the operation
    always_comb begin
        for (int a = 0; a < n_apus; a++) begin
            target[a] = '0;
            if (apu_req_us[a]) begin
                target[a][apu_tag_us[a][w_apu_tag-1:w_cpu_tag]] = 1'b1;
            end
        end
    end

    // scanning downwards leaves the lowest targeting APU as the winner
    always_comb begin
        for (int c = 0; c < n_cpus; c++) begin
            hit[c] = 1'b0;
            win[c] = '0;
            for (int a = n_apus - 1; a >= 0; a--) begin
                if (target[a][c]) begin
                    hit[c] = 1'b1;
                    win[c] = w_apu_idx'(a);
                end
            end
        end
    end

    ////////////////////////////////////////
    // upstream routing
    ////////////////////////////////////////

    // a core without a targeting APU sees zero payload
    always_comb begin
        for (int c = 0; c < n_cpus; c++) begin
            valid_us[c]  = hit[c];
            result_us[c] = hit[c] ? apu_result_us[win[c]] : '0;
            tag_us[c]    = hit[c] ? apu_tag_us[win[c]][w_cpu_tag-1:0] : '0;
        end
    end

    // only the winner is acknowledged, and only when its core can take the result
    // a losing APU keeps its request up until the winner has moved on
    always_comb begin
        apu_ack_us = '0;
        for (int c = 0; c < n_cpus; c++) begin
            for (int a = 0; a < n_apus; a++) begin
                if (hit[c] && win[c] == w_apu_idx'(a) && ready_us[c]) begin
                    apu_ack_us[a] = 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/marx.sv
// shared APU interconnect top that joins the dispatch and return paths between cores and APUs
module marx
    import marx_topo_pkg::*;
    import apu_op_pkg::*;
(
    input  logic                                         clk_ci,
    input  logic                                         rst_n,
    // core requests and their acknowledge
    input  logic [n_cpus-1:0]                            req_ds,
    input  logic [n_cpus-1:0][w_type-1:0]                type_ds,
    input  logic [n_cpus-1:0][w_op-1:0]                  op_ds,
    input  logic [n_cpus-1:0][n_args-1:0][w_operand-1:0] operands_ds,
    input  logic [n_cpus-1:0][w_cpu_tag-1:0]             tag_ds,
    output logic [n_cpus-1:0]                            ack_ds,
    // results towards the cores
    input  logic [n_cpus-1:0]                            ready_us,
    output logic [n_cpus-1:0]                            valid_us,
    output logic [n_cpus-1:0][w_operand-1:0]             result_us,
    output logic [n_cpus-1:0][w_cpu_tag-1:0]             tag_us,
    // operations towards the APUs
    input  logic [n_apus-1:0]                            apu_ready_ds,
    output logic [n_apus-1:0]                            apu_valid_ds,
    output logic [n_apus-1:0][w_op-1:0]                  apu_op_ds,
    output logic [n_apus-1:0][n_args-1:0][w_operand-1:0] apu_operands_ds,
    output logic [n_apus-1:0][w_apu_tag-1:0]             apu_tag_ds,
    // APU results and their acknowledge
    input  logic [n_apus-1:0]                            apu_req_us,
    input  logic [n_apus-1:0][w_operand-1:0]             apu_result_us,
    input  logic [n_apus-1:0][w_apu_tag-1:0]             apu_tag_us,
    output logic [n_apus-1:0]                            apu_ack_us
);

    ////////////////////////////////////////
    // downstream from the cores to the APUs
    ////////////////////////////////////////

    marx_dispatch i_marx_dispatch (
        .clk_ci          (clk_ci),
        .rst_n           (rst_n),
        .req_ds          (req_ds),
        .type_ds         (type_ds),
        .op_ds           (op_ds),
        .operands_ds     (operands_ds),
        .tag_ds          (tag_ds),
        .ack_ds          (ack_ds),
        .apu_ready_ds    (apu_ready_ds),
        .apu_valid_ds    (apu_valid_ds),
        .apu_op_ds       (apu_op_ds),
        .apu_operands_ds (apu_operands_ds),
        .apu_tag_ds      (apu_tag_ds)
    );

    ////////////////////////////////////////
    // upstream from the APUs to the cores
    ////////////////////////////////////////

    // results pass from the APUs to the cores within the same cycle
    marx_return i_marx_return (
        .apu_req_us    (apu_req_us),
        .apu_result_us (apu_result_us),
        .apu_tag_us    (apu_tag_us),
        .apu_ack_us    (apu_ack_us),
        .ready_us      (ready_us),
        .valid_us      (valid_us),
        .result_us     (result_us),
        .tag_us        (tag_us)
    );

endmodule

// File: test/marx_checker.sv
// interconnect checker bound to marx that checks grants, routing, fairness and result return
module marx_checker
    import marx_topo_pkg::*;
    import apu_op_pkg::*;
(
    input logic                                         clk_ci,
    input logic                                         rst_n,
    input logic [n_cpus-1:0]                            req_ds,
    input logic [n_cpus-1:0][w_type-1:0]                type_ds,
    input logic [n_cpus-1:0][w_op-1:0]                  op_ds,
    input logic [n_cpus-1:0][n_args-1:0][w_operand-1:0] operands_ds,
    input logic [n_cpus-1:0][w_cpu_tag-1:0]             tag_ds,
    input logic [n_cpus-1:0]                            ack_ds,
    input logic [n_cpus-1:0]                            ready_us,
    input logic [n_cpus-1:0]                            valid_us,
    input logic [n_cpus-1:0][w_operand-1:0]             result_us,
    input logic [n_cpus-1:0][w_cpu_tag-1:0]             tag_us,
    input logic [n_apus-1:0]                            apu_ready_ds,
    input logic [n_apus-1:0]                            apu_valid_ds,
    input logic [n_apus-1:0][w_op-1:0]                  apu_op_ds,
    input logic [n_apus-1:0][n_args-1:0][w_operand-1:0] apu_operands_ds,
    input logic [n_apus-1:0][w_apu_tag-1:0]             apu_tag_ds,
    input logic [n_apus-1:0]                            apu_req_us,
    input logic [n_apus-1:0][w_operand-1:0]             apu_result_us,
    input logic [n_apus-1:0][w_apu_tag-1:0]             apu_tag_us,
    input logic [n_apus-1:0]                            apu_ack_us
);

    logic [n_cpus-1:0]                matching;
    int                               exp_grants;
    logic [n_apus-1:0]                route_bad;
    logic [n_cpus-1:0]                exp_valid;
    logic [n_cpus-1:0][w_operand-1:0] exp_result;
    logic [n_cpus-1:0][w_cpu_tag-1:0] exp_tag;
    logic [n_apus-1:0]                exp_ack;
    int                               waited [n_cpus];
    logic [n_cpus-1:0]                starved;

    // sticky flags, one per assertion, that the testbench watches
    logic fail_filter = 1'b0;
    logic fail_count  = 1'b0;
    logic fail_route  = 1'b0;
    logic fail_fair   = 1'b0;
    logic fail_return = 1'b0;
    logic failed;

    assign failed = fail_filter | fail_count | fail_route | fail_fair | fail_return;

    ////////////////////////////////////////
    // downstream expectations
    ////////////////////////////////////////

    // a request only counts when its type is the served one
    // and every granted APU must carry exactly the payload of the core it names
    always_comb begin
        logic [w_cpu_idx-1:0] src;
        for (int c = 0; c < n_cpus; c++) begin
            matching[c] = req_ds[c] && (type_ds[c] == apu_type);
        end
        exp_grants = $countones(matching);
        if ($countones(apu_ready_ds) < exp_grants) begin
            exp_grants = $countones(apu_ready_ds);
        end
        route_bad = '0;
        for (int a = 0; a < n_apus; a++) begin
            src = apu_tag_ds[a][w_apu_tag-1:w_cpu_tag];
            if (apu_valid_ds[a]) begin
                if (!ack_ds[src] || apu_op_ds[a] != op_ds[src]
                        || apu_operands_ds[a] != operands_ds[src]
                        || apu_tag_ds[a][w_cpu_tag-1:0] != tag_ds[src]) begin
                    route_bad[a] = 1'b1;
                end
            end
        end
    end

    // counts the cycles a matching core has waited while some APU could accept
    // a cycle with no ready APU neither counts nor clears the wait
    always_ff @(posedge clk_ci) begin
        for (int c = 0; c < n_cpus; c++) begin
            if (!rst_n || !matching[c] || ack_ds[c]) begin
                waited[c] <= 0;
            end else if (|apu_ready_ds) begin
                waited[c] <= waited[c] + 1;
            end
        end
    end

    always_comb begin
        for (int c = 0; c < n_cpus; c++) begin
            starved[c] = (waited[c] >= n_cpus);
        end
    end

    ////////////////////////////////////////
    // upstream expectations
    ////////////////////////////////////////

    // walking APUs upwards, the first one that names a core owns that core
    always_comb begin
        exp_valid  = '0;
        exp_result = '0;
        exp_tag    = '0;
        exp_ack    = '0;
        for (int c = 0; c < n_cpus; c++) begin
            for (int a = 0; a < n_apus; a++) begin
                if (!exp_valid[c] && apu_req_us[a]
                        && apu_tag_us[a][w_apu_tag-1:w_cpu_tag] == w_cpu_idx'(c)) begin
                    exp_valid[c]  = 1'b1;
                    exp_result[c] = apu_result_us[a];
                    exp_tag[c]    = apu_tag_us[a][w_cpu_tag-1:0];
                    exp_ack[a]    = ready_us[c];
                end
            end
        end
    end

    ////////////////////////////////////////
    // assertions
    ////////////////////////////////////////

    a_type_filter: assert property (@(posedge clk_ci) disable iff (!rst_n)
        (ack_ds & ~matching) == '0)
    else begin
        fail_filter = 1'b1;
        $error("mismatch: type_filter expected ack_ds within %b actual %b", matching, ack_ds);
    end

    a_grant_count: assert property (@(posedge clk_ci) disable iff (!rst_n)
        $countones(apu_valid_ds) == $countones(ack_ds)
        && $countones(ack_ds) == exp_grants
        && (apu_valid_ds & ~apu_ready_ds) == '0)
    else begin
        fail_count = 1'b1;
        $error("mismatch: grant_count expected %0d actual ack %b valid %b ready %b",
               exp_grants, ack_ds, apu_valid_ds, apu_ready_ds);
    end

    a_ds_routing: assert property (@(posedge clk_ci) disable iff (!rst_n)
        route_bad == '0)
    else begin
        fail_route = 1'b1;
        $error("mismatch: ds_routing expected no misrouted APU actual misrouted %b",
               route_bad);
    end

    a_fairness: assert property (@(posedge clk_ci) disable iff (!rst_n)
        starved == '0)
    else begin
        fail_fair = 1'b1;
        $error("a matching core was passed over for more than n_cpus cycles");
    end

    a_us_routing: assert property (@(posedge clk_ci) disable iff (!rst_n)
        valid_us == exp_valid && result_us == exp_result
        && tag_us == exp_tag && apu_ack_us == exp_ack)
    else begin
        fail_return = 1'b1;
        $error({"mismatch: us_routing expected valid %b ack %b result %h tag %h",
                " actual valid %b ack %b result %h tag %h"},
               exp_valid, exp_ack, exp_result, exp_tag,
               valid_us, apu_ack_us, result_us, tag_us);
    end

endmodule

bind marx marx_checker i_marx_checker (.*);

// File: test/marx_clock.sv
// testbench clock source that gives the interconnect one cycle every 100 time units
module marx_clock (
    output logic clk_ci
);

    // the clock starts low and toggles every half period
    initial begin
        clk_ci = 1'b0;
        forever begin
            #50;
            clk_ci = ~clk_ci;
        end
    end

endmodule

// File: test/marx_tb.sv
// testbench for the shared APU interconnect with random model cores and model APUs
module marx_tb
    import marx_topo_pkg::*;
    import apu_op_pkg::*;
();

    localparam int n_cycles   = 2000;
    localparam int wait_limit = 500;
    localparam int fifo_depth = 4;

    logic                                         clk_ci;
    logic                                         rst_n;
    logic [n_cpus-1:0]                            req_ds;
    logic [n_cpus-1:0][w_type-1:0]                type_ds;
    logic [n_cpus-1:0][w_op-1:0]                  op_ds;
    logic [n_cpus-1:0][n_args-1:0][w_operand-1:0] operands_ds;
    logic [n_cpus-1:0][w_cpu_tag-1:0]             tag_ds;
    logic [n_cpus-1:0]                            ack_ds;
    logic [n_cpus-1:0]                            ready_us;
    logic [n_cpus-1:0]                            valid_us;
    logic [n_cpus-1:0][w_operand-1:0]             result_us;
    logic [n_cpus-1:0][w_cpu_tag-1:0]             tag_us;
    logic [n_apus-1:0]                            apu_ready_ds;
    logic [n_apus-1:0]                            apu_valid_ds;
    logic [n_apus-1:0][w_op-1:0]                  apu_op_ds;
    logic [n_apus-1:0][n_args-1:0][w_operand-1:0] apu_operands_ds;
    logic [n_apus-1:0][w_apu_tag-1:0]             apu_tag_ds;
    logic [n_apus-1:0]                            apu_req_us;
    logic [n_apus-1:0][w_operand-1:0]             apu_result_us;
    logic [n_apus-1:0][w_apu_tag-1:0]             apu_tag_us;
    logic [n_apus-1:0]                            apu_ack_us;

    // the tags per core that were handed over and still wait for their result
    bit                             pend [n_cpus][2**w_cpu_tag];
    logic [w_operand-1:0]           exp_sum [n_cpus][2**w_cpu_tag];
    int                             next_tag [n_cpus];
    int                             core_gap [n_cpus];
    int                             core_hold [n_cpus];
    // each model APU keeps {result, extended tag} of its accepted operations
    logic [w_operand+w_apu_tag-1:0] fifo [n_apus][$];
    int                             apu_delay [n_apus];
    int                             apu_hold [n_apus];

    marx_clock i_marx_clock (
        .clk_ci (clk_ci)
    );

    marx i_marx (.*);

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    // counts everything still in flight from held requests to results not yet delivered
    function automatic int outstanding_count();
        int n;
        n = 0;
        for (int c = 0; c < n_cpus; c++) begin
            if (req_ds[c] && type_ds[c] == apu_type) begin
                n++;
            end
            for (int t = 0; t < 2**w_cpu_tag; t++) begin
                if (pend[c][t]) begin
                    n++;
                end
            end
        end
        for (int a = 0; a < n_apus; a++) begin
            n += fifo[a].size();
        end
        return n;
    endfunction

    // runs one cycle of all model cores and APUs at the falling edge
    // the DUT outputs are copied first, so they still show the last rising edge
    task automatic step_models(input logic issue_en);
        logic [n_cpus-1:0]                            ack_s;
        logic [n_cpus-1:0]                            valid_s;
        logic [n_cpus-1:0][w_operand-1:0]             result_s;
        logic [n_cpus-1:0][w_cpu_tag-1:0]             tag_s;
        logic [n_apus-1:0]                            avalid_s;
        logic [n_apus-1:0][n_args-1:0][w_operand-1:0] aops_s;
        logic [n_apus-1:0][w_apu_tag-1:0]             atag_s;
        logic [n_apus-1:0]                            aack_s;
        logic [w_operand-1:0]                         sum;
        logic [w_cpu_tag-1:0]                         t;
        ack_s    = ack_ds;
        valid_s  = valid_us;
        result_s = result_us;
        tag_s    = tag_us;
        avalid_s = apu_valid_ds;
        aops_s   = apu_operands_ds;
        atag_s   = apu_tag_ds;
        aack_s   = apu_ack_us;
        if (i_marx.i_marx_checker.failed) begin
            fail_run("an interconnect assertion failed");
        end

        // cores take results that were transferred at the last edge
        for (int c = 0; c < n_cpus; c++) begin
            if (valid_s[c] && ready_us[c]) begin
                t = tag_s[c];
                if (!pend[c][t]) begin
                    fail_run($sformatf("core %0d got tag %0d that it never sent", c, t));
                end else if (result_s[c] !== exp_sum[c][t]) begin
                    fail_run($sformatf(
                        "mismatch: end_to_end core %0d tag %0d expected %h actual %h",
                        c, t, exp_sum[c][t], result_s[c]));
                end
                pend[c][t] = 1'b0;
            end
        end

        for (int c = 0; c < n_cpus; c++) begin
            if (req_ds[c] && ack_s[c]) begin
                sum = '0;
                for (int k = 0; k < n_args; k++) begin
                    sum += operands_ds[c][k];
                end
                pend[c][tag_ds[c]]    = 1'b1;
                exp_sum[c][tag_ds[c]] = sum;
                next_tag[c]           = (next_tag[c] + 1) % (2**w_cpu_tag);
                req_ds[c]             = 1'b0;
                core_gap[c]           = $urandom_range(0, 4);
            end else if (req_ds[c] && type_ds[c] != apu_type) begin
                // a request of another type is meant for another unit and is dropped
                core_hold[c]++;
                if (core_hold[c] >= 3) begin
                    req_ds[c]   = 1'b0;
                    core_gap[c] = $urandom_range(0, 4);
                end
            end else if (req_ds[c]) begin
                core_hold[c]++;
                if (core_hold[c] > wait_limit) begin
                    fail_run($sformatf("timeout: core %0d never saw ack_ds", c));
                end
            end else if (core_gap[c] > 0) begin
                core_gap[c]--;
            end else if (issue_en && !pend[c][next_tag[c]]) begin
                req_ds[c] = 1'b1;
                if ($urandom_range(0, 3) != 0) begin
                    type_ds[c] = apu_type;
                end else begin
                    type_ds[c] = apu_type + w_type'($urandom_range(1, 3));
                end
                op_ds[c] = w_op'($urandom());
                for (int k = 0; k < n_args; k++) begin
                    operands_ds[c][k] = $urandom();
                end
                tag_ds[c]    = w_cpu_tag'(next_tag[c]);
                core_hold[c] = 0;
            end
            ready_us[c] = ($urandom_range(0, 3) != 0);
        end

        for (int a = 0; a < n_apus; a++) begin
            if (avalid_s[a]) begin
                sum = '0;
                for (int k = 0; k < n_args; k++) begin
                    sum += aops_s[a][k];
                end
                fifo[a].push_back({sum, atag_s[a]});
            end
            if (apu_req_us[a] && aack_s[a]) begin
                void'(fifo[a].pop_front());
                apu_req_us[a] = 1'b0;
                apu_delay[a]  = $urandom_range(0, 3);
            end else if (apu_req_us[a]) begin
                apu_hold[a]++;
                if (apu_hold[a] > wait_limit) begin
                    fail_run($sformatf("timeout: APU %0d never saw ack_us", a));
                end
            end else if (apu_delay[a] > 0) begin
                apu_delay[a]--;
            end else if (fifo[a].size() > 0) begin
                {apu_result_us[a], apu_tag_us[a]} = fifo[a][0];
                apu_req_us[a] = 1'b1;
                apu_hold[a]   = 0;
            end
            apu_ready_ds[a] = ($urandom_range(0, 2) != 0) && (fifo[a].size() < fifo_depth);
        end
    endtask

    ////////////////////////////////////////
    // run
    ////////////////////////////////////////

    initial begin
        int waited;
        void'($urandom(23239));
        rst_n         = 1'b0;
        req_ds        = '0;
        type_ds       = '0;
        op_ds         = '0;
        operands_ds   = '0;
        tag_ds        = '0;
        ready_us      = '0;
        apu_ready_ds  = '0;
        apu_req_us    = '0;
        apu_result_us = '0;
        apu_tag_us    = '0;
        repeat (5) @(negedge clk_ci);
        rst_n = 1'b1;

        for (int cyc = 0; cyc < n_cycles; cyc++) begin
            @(negedge clk_ci);
            step_models(1'b1);
        end

        // with no new requests everything in flight comes back
        waited = 0;
        while (outstanding_count() != 0 && waited < wait_limit) begin
            @(negedge clk_ci);
            step_models(1'b0);
            waited++;
        end

        if (outstanding_count() != 0) begin
            fail_run("timeout: requests still outstanding at the end of the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: verilog.f
verilog/marx_topo_pkg.sv
verilog/apu_op_pkg.sv
verilog/marx_arbiter.sv
verilog/marx_dispatch.sv
verilog/marx_return.sv
verilog/marx.sv
test/marx_checker.sv
test/marx_clock.sv
test/marx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module marx_tb \
        -f verilog.f -o marx_sim; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/marx_sim +verilator+error+limit+100)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
